// ==== common/board_pkg.sv ====
package board_pkg;

	// one word of slide switches
	typedef logic [15:0] switch_t;

	// one button row
	typedef logic [3:0] btn_t;

	// eight hex nibbles, digit 7 in the top nibble
	typedef logic [31:0] disp_data_t;

	// led pattern, led 15 shifted first
	typedef logic [15:0] led_t;

	// frame event counter, shown on digits 7..4
	typedef logic [15:0] event_cnt_t;

	// one digit, active low
	// bit 7 is the decimal point, bits 6..0 are segments g..a
	typedef logic [7:0] seg_t;

	// display serializer states
	typedef enum logic [1:0] {
		idle,
		shift_seg,
		shift_led,
		latch
	} disp_state_t;

	// bits per frame on each serial chain
	localparam int SEG_BITS = 64;
	localparam int LED_BITS = 16;

	// nibble to segment pattern, decimal point off
	function automatic seg_t hex_to_seg(input logic [3:0] nib);
		logic [6:0] on;
		// active high gfedcba first
		case (nib)
			4'h0: on = 7'h3f;
			4'h1: on = 7'h06;
			4'h2: on = 7'h5b;
			4'h3: on = 7'h4f;
			4'h4: on = 7'h66;
			4'h5: on = 7'h6d;
			4'h6: on = 7'h7d;
			4'h7: on = 7'h07;
			4'h8: on = 7'h7f;
			4'h9: on = 7'h6f;
			4'ha: on = 7'h77;
			4'hb: on = 7'h7c;
			4'hc: on = 7'h39;
			4'hd: on = 7'h5e;
			4'he: on = 7'h79;
			default: on = 7'h71;
		endcase
		// segments sink current, so invert
		return {1'b1, ~on};
	endfunction

endpackage

// ==== verilog/anti_jitter.sv ====
`timescale 1ns/1ps

module anti_jitter #(
	parameter int WIDTH = 16,
	parameter int JITTER_MAX = 10000
) (
	input  logic             clk_cpu,
	input  logic             rst_n_i,
	input  logic [WIDTH-1:0] sig_i,
	output logic [WIDTH-1:0] sig_o
);

	localparam int CNT_W = $clog2(JITTER_MAX + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(JITTER_MAX - 1);

	// two flop synchronizer
	logic [WIDTH-1:0] sync_1;
	logic [WIDTH-1:0] sync_2;
	// value seen on the previous cycle
	logic [WIDTH-1:0] sync_last;
	// cycles the current value has held, minus one
	logic [CNT_W-1:0] stable_cnt;
	logic             same;

	assign same = (sync_2 == sync_last);

	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sync_1 <= '0;
			sync_2 <= '0;
			sync_last <= '0;
			stable_cnt <= '0;
			sig_o <= '0;
		end else begin
			sync_1 <= sig_i;
			sync_2 <= sync_1;
			sync_last <= sync_2;
			// any bit moving restarts the count
			if (!same) begin
				stable_cnt <= CNT_W'(1);
			end else if (stable_cnt != CNT_LAST) begin
				stable_cnt <= stable_cnt + 1'b1;
			end
			// held long enough, output follows
			if (same && stable_cnt == CNT_LAST) begin
				sig_o <= sync_last;
			end
		end
	end

endmodule

// ==== switch_probe/switch_probe.sv ====
`timescale 1ns/1ps

module switch_probe import board_pkg::*; (
	input  logic       clk_cpu,
	input  logic       rst_n_i,
	input  switch_t    switch_i,
	input  btn_t       btn_i,
	output logic       frame_valid_o,
	input  logic       frame_ready_i,
	output disp_data_t frame_data_o,
	output led_t       frame_led_o
);

	// last value put into a frame
	switch_t    last_sw;
	// count carried by the next normal frame
	event_cnt_t event_cnt;
	// clear button edge detect
	logic       btn0_q;
	logic       btn_rise;
	// clear seen while a frame was still pending
	logic       clr_pend;

	logic       clr_req;
	logic       sw_change;
	logic       accept;
	logic       load_clr;
	logic       load_sw;

	assign btn_rise = btn_i[0] & ~btn0_q;
	assign clr_req = clr_pend | btn_rise;
	assign sw_change = (switch_i != last_sw);
	assign accept = frame_valid_o & frame_ready_i;

	// new frames only while nothing is pending
	// clear wins over a plain switch change
	assign load_clr = ~frame_valid_o & clr_req;
	assign load_sw = ~frame_valid_o & ~clr_req & sw_change;

	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			frame_valid_o <= 1'b0;
			last_sw <= '0;
			event_cnt <= '0;
			btn0_q <= 1'b0;
			clr_pend <= 1'b0;
		end else begin
			btn0_q <= btn_i[0];
			// remember a press until it can be sent
			if (btn_rise) begin
				clr_pend <= 1'b1;
			end
			if (accept) begin
				frame_valid_o <= 1'b0;
				event_cnt <= event_cnt + 1'b1;
			end else if (load_clr) begin
				frame_valid_o <= 1'b1;
				clr_pend <= 1'b0;
				// cleared frame shows 0, next one shows 1
				event_cnt <= '0;
				last_sw <= switch_i;
			end else if (load_sw) begin
				frame_valid_o <= 1'b1;
				last_sw <= switch_i;
			end
		end
	end

	// frame payload, held while valid is up
	always_ff @(posedge clk_cpu) begin
		if (load_clr) begin
			frame_data_o <= {16'h0000, switch_i};
			frame_led_o <= switch_i;
		end else if (load_sw) begin
			// count on digits 7..4, switches on 3..0
			frame_data_o <= {event_cnt, switch_i};
			frame_led_o <= switch_i;
		end
	end

endmodule

// ==== verilog/disp_fifo.sv ====
`timescale 1ns/1ps

module disp_fifo import board_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic       clk_cpu,
	input  logic       rst_n_i,
	input  logic       wr_valid_i,
	output logic       wr_ready_o,
	input  disp_data_t wr_data_i,
	input  led_t       wr_led_i,
	output logic       rd_valid_o,
	input  logic       rd_ready_i,
	output disp_data_t rd_data_o,
	output led_t       rd_led_o
);

	localparam int AW = $clog2(FIFO_DEPTH);

	// frame storage, digits and leds side by side
	disp_data_t data_mem [FIFO_DEPTH];
	led_t       led_mem [FIFO_DEPTH];

	// pointers wrap on their own, depth is a power of two
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	// occupancy, one bit wider to hold full
	logic [AW:0]   count;

	logic full;
	logic do_wr;
	logic do_rd;

	assign full = (count == (AW+1)'(FIFO_DEPTH));
	assign rd_valid_o = (count != '0);
	// full still takes a write when a read leaves the same cycle
	assign wr_ready_o = ~full | rd_ready_i;

	assign do_wr = wr_valid_i & wr_ready_o;
	assign do_rd = rd_valid_o & rd_ready_i;

	// head of the queue straight out of storage
	assign rd_data_o = data_mem[rd_ptr];
	assign rd_led_o = led_mem[rd_ptr];

	always_ff @(posedge clk_cpu) begin
		if (do_wr) begin
			data_mem[wr_ptr] <= wr_data_i;
			led_mem[wr_ptr] <= wr_led_i;
		end
	end

	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// both at once leaves the level alone
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== board_disp/board_disp.sv ====
`timescale 1ns/1ps

module board_disp import board_pkg::*; #(
	parameter int SHIFT_DIV = 5
) (
	input  logic       clk_cpu,
	input  logic       rst_n_i,
	input  logic       disp_valid_i,
	output logic       disp_ready_o,
	input  disp_data_t disp_data_i,
	input  led_t       disp_led_i,
	output logic       seg_clk_o,
	output logic       seg_do_o,
	output logic       seg_pen_o,
	output logic       seg_clr_n_o,
	output logic       led_clk_o,
	output logic       led_do_o,
	output logic       led_pen_o,
	output logic       led_clr_n_o
);

	localparam int DIV_W = (SHIFT_DIV > 1) ? $clog2(SHIFT_DIV) : 1;
	localparam int BIT_W = $clog2(SEG_BITS);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SHIFT_DIV - 1);
	localparam logic [BIT_W-1:0] SEG_LAST = BIT_W'(SEG_BITS - 1);
	localparam logic [BIT_W-1:0] LED_LAST = BIT_W'(LED_BITS - 1);

	disp_state_t state;

	// half period divider for the shift clocks
	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	// bits sent on the current chain
	logic [BIT_W-1:0] bit_cnt;

	logic [SEG_BITS-1:0] seg_sr;
	logic [LED_BITS-1:0] led_sr;
	logic [SEG_BITS-1:0] seg_word;

	logic seg_clk_q;
	logic led_clk_q;
	logic pen_q;
	logic accept;

	assign tick = (div_cnt == DIV_LAST);
	assign disp_ready_o = (state == idle);
	assign accept = disp_valid_i & disp_ready_o;

	// digit 7 lands in the top byte, so it leaves first
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			seg_word[8*i +: 8] = hex_to_seg(disp_data_i[4*i +: 4]);
		end
	end

	// msb of each chain drives the data pin
	assign seg_do_o = seg_sr[SEG_BITS-1];
	assign led_do_o = led_sr[LED_BITS-1];
	assign seg_clk_o = seg_clk_q;
	assign led_clk_o = led_clk_q;
	// both chains latch on the same pulse
	assign seg_pen_o = pen_q;
	assign led_pen_o = pen_q;
	// shift registers are never cleared
	assign seg_clr_n_o = 1'b1;
	assign led_clr_n_o = 1'b1;

	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= idle;
			div_cnt <= '0;
			bit_cnt <= '0;
			seg_sr <= '0;
			led_sr <= '0;
			seg_clk_q <= 1'b0;
			led_clk_q <= 1'b0;
			pen_q <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (accept) begin
						seg_sr <= seg_word;
						led_sr <= disp_led_i;
						div_cnt <= '0;
						bit_cnt <= '0;
						state <= shift_seg;
					end
				end
				shift_seg: begin
					if (!tick) begin
						div_cnt <= div_cnt + 1'b1;
					end else begin
						div_cnt <= '0;
						if (!seg_clk_q) begin
							// data has settled during the low half
							seg_clk_q <= 1'b1;
						end else begin
							// falling edge moves to the next bit
							seg_clk_q <= 1'b0;
							seg_sr <= {seg_sr[SEG_BITS-2:0], 1'b0};
							if (bit_cnt == SEG_LAST) begin
								bit_cnt <= '0;
								state <= shift_led;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
					end
				end
				shift_led: begin
					if (!tick) begin
						div_cnt <= div_cnt + 1'b1;
					end else begin
						div_cnt <= '0;
						if (!led_clk_q) begin
							led_clk_q <= 1'b1;
						end else begin
							led_clk_q <= 1'b0;
							led_sr <= {led_sr[LED_BITS-2:0], 1'b0};
							if (bit_cnt == LED_LAST) begin
								bit_cnt <= '0;
								// pen goes high right after the last bit
								pen_q <= 1'b1;
								state <= latch;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
					end
				end
				latch: begin
					// pen held for one half period
					if (!tick) begin
						div_cnt <= div_cnt + 1'b1;
					end else begin
						div_cnt <= '0;
						pen_q <= 1'b0;
						state <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

// ==== verilog/test_frame.sv ====
`timescale 1ns/1ps

module test_frame import board_pkg::*; #(
	parameter int JITTER_MAX = 10000,
	parameter int SHIFT_DIV = 5,
	parameter int FIFO_DEPTH = 4
) (
	input  logic    clk_cpu,
	input  logic    rst_n_i,
	input  switch_t switch_i,
	input  btn_t    btn_y_i,
	output logic    seg_clk_o,
	output logic    seg_do_o,
	output logic    seg_pen_o,
	output logic    seg_clr_n_o,
	output logic    led_clk_o,
	output logic    led_do_o,
	output logic    led_pen_o,
	output logic    led_clr_n_o
);

	// settled board inputs
	switch_t    switch_buf;
	btn_t       btn_buf;

	// probe to buffer
	logic       frame_valid;
	logic       frame_ready;
	disp_data_t frame_data;
	led_t       frame_led;

	// buffer to display
	logic       disp_valid;
	logic       disp_ready;
	disp_data_t disp_data;
	led_t       disp_led;

	anti_jitter #(
		.WIDTH($bits(switch_t)),
		.JITTER_MAX(JITTER_MAX)
	) u_aj_sw (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.sig_i(switch_i),
		.sig_o(switch_buf)
	);

	anti_jitter #(
		.WIDTH($bits(btn_t)),
		.JITTER_MAX(JITTER_MAX)
	) u_aj_btn (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.sig_i(btn_y_i),
		.sig_o(btn_buf)
	);

	switch_probe u_probe (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.switch_i(switch_buf),
		.btn_i(btn_buf),
		.frame_valid_o(frame_valid),
		.frame_ready_i(frame_ready),
		.frame_data_o(frame_data),
		.frame_led_o(frame_led)
	);

	disp_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.wr_valid_i(frame_valid),
		.wr_ready_o(frame_ready),
		.wr_data_i(frame_data),
		.wr_led_i(frame_led),
		.rd_valid_o(disp_valid),
		.rd_ready_i(disp_ready),
		.rd_data_o(disp_data),
		.rd_led_o(disp_led)
	);

	board_disp #(
		.SHIFT_DIV(SHIFT_DIV)
	) u_disp (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.disp_valid_i(disp_valid),
		.disp_ready_o(disp_ready),
		.disp_data_i(disp_data),
		.disp_led_i(disp_led),
		.seg_clk_o(seg_clk_o),
		.seg_do_o(seg_do_o),
		.seg_pen_o(seg_pen_o),
		.seg_clr_n_o(seg_clr_n_o),
		.led_clk_o(led_clk_o),
		.led_do_o(led_do_o),
		.led_pen_o(led_pen_o),
		.led_clr_n_o(led_clr_n_o)
	);

endmodule

// ==== testbench/tb_shift_monitor.sv ====
`timescale 1ns/1ps

module tb_shift_monitor import board_pkg::*; (
	input  logic       rst_n_i,
	input  logic       seg_clk_i,
	input  logic       seg_do_i,
	input  logic       seg_pen_i,
	input  logic       led_clk_i,
	input  logic       led_do_i,
	output int         frame_cnt_o,
	output disp_data_t data_o,
	output led_t       led_o,
	output logic       dp_off_o,
	output int         err_cnt_o
);

	// serial chains as seen on the pins, first bit ends up on top
	logic [SEG_BITS-1:0] seg_sh;
	logic [LED_BITS-1:0] led_sh;
	int                  seg_n;
	int                  led_n;
	// frame closed by pen rise, not yet handed over
	logic                latched;

	// lit segments gfedcba back to a nibble
	// bit 4 set means no hex digit matches
	function automatic logic [4:0] seg_to_nibble(input logic [6:0] lit);
		case (lit)
			7'h3f: return 5'h00;
			7'h06: return 5'h01;
			7'h5b: return 5'h02;
			7'h4f: return 5'h03;
			7'h66: return 5'h04;
			7'h6d: return 5'h05;
			7'h7d: return 5'h06;
			7'h07: return 5'h07;
			7'h7f: return 5'h08;
			7'h6f: return 5'h09;
			7'h77: return 5'h0a;
			7'h7c: return 5'h0b;
			7'h39: return 5'h0c;
			7'h5e: return 5'h0d;
			7'h79: return 5'h0e;
			7'h71: return 5'h0f;
			default: return 5'h10;
		endcase
	endfunction

	initial begin
		frame_cnt_o = 0;
		err_cnt_o = 0;
		seg_n = 0;
		led_n = 0;
		latched = 1'b0;
		data_o = '0;
		led_o = '0;
		dp_off_o = 1'b1;
	end

	// data is stable at the rising shift clock
	always @(posedge seg_clk_i) begin
		if (rst_n_i) begin
			seg_sh = {seg_sh[SEG_BITS-2:0], seg_do_i};
			seg_n++;
		end
	end

	always @(posedge led_clk_i) begin
		if (rst_n_i) begin
			led_sh = {led_sh[LED_BITS-2:0], led_do_i};
			led_n++;
		end
	end

	// pen rise closes the frame
	always @(posedge seg_pen_i) begin
		logic [4:0] nib;
		if (rst_n_i) begin
			assert (seg_n == SEG_BITS && led_n == LED_BITS) else begin
				$display("monitor: latch pulse after %0d segment bits and %0d led bits",
					seg_n, led_n);
				err_cnt_o++;
			end
			dp_off_o = 1'b1;
			for (int d = 0; d < 8; d++) begin
				// active low, so a set bit 7 is a dark point
				if (!seg_sh[8*d+7]) begin
					dp_off_o = 1'b0;
				end
				nib = seg_to_nibble(~seg_sh[8*d +: 7]);
				assert (!nib[4]) else begin
					$display("monitor: digit %0d shows no valid hex pattern", d);
					err_cnt_o++;
				end
				data_o[4*d +: 4] = nib[3:0];
			end
			led_o = led_sh;
			seg_n = 0;
			led_n = 0;
			latched = 1'b1;
		end
	end

	// handed over once the pulse is gone
	always @(negedge seg_pen_i) begin
		if (latched) begin
			latched = 1'b0;
			frame_cnt_o++;
		end
	end

endmodule

// ==== testbench/tb_test_frame.sv ====
`timescale 1ns/1ps

module tb_test_frame import board_pkg::*; ();

	localparam int JITTER_MAX = 4;
	localparam int SHIFT_DIV = 2;
	localparam int FIFO_DEPTH = 4;
	// shift and latch time of one frame, plus slack for settling
	localparam int FRAME_CYC = 2 * SHIFT_DIV * (SEG_BITS + LED_BITS + 1) + 200;
	localparam int MAX_STEPS = 32;

	// step kinds
	localparam int K_QUIET = 0;
	localparam int K_FRAME = 1;
	localparam int K_BURST = 2;
	localparam int K_LAST = 3;

	logic    clk_cpu;
	logic    rst_n;
	switch_t sw;
	btn_t    btn_y;
	logic    seg_clk;
	logic    seg_do;
	logic    seg_pen;
	logic    seg_clr_n;
	logic    led_clk;
	logic    led_do;
	logic    led_pen;
	logic    led_clr_n;

	// frames decoded from the pins
	int         mon_frames;
	disp_data_t mon_data;
	led_t       mon_led;
	logic       mon_dp_off;
	int         mon_errs;
	// led latch pulses seen so far
	int         led_pens;

	// stimulus table, one row per step
	switch_t    tab_sw [MAX_STEPS];
	btn_t       tab_btn [MAX_STEPS];
	int         tab_hold [MAX_STEPS];
	int         tab_kind [MAX_STEPS];
	event_cnt_t tab_cnt [MAX_STEPS];
	int         n_steps;

	int         frames_seen;
	event_cnt_t last_cnt;
	int         val_errs;
	int         other_errs;
	int         limit_cyc;

	initial clk_cpu = 1'b0;
	always #2 clk_cpu = ~clk_cpu;

	test_frame #(
		.JITTER_MAX(JITTER_MAX),
		.SHIFT_DIV(SHIFT_DIV),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_dut (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n),
		.switch_i(sw),
		.btn_y_i(btn_y),
		.seg_clk_o(seg_clk),
		.seg_do_o(seg_do),
		.seg_pen_o(seg_pen),
		.seg_clr_n_o(seg_clr_n),
		.led_clk_o(led_clk),
		.led_do_o(led_do),
		.led_pen_o(led_pen),
		.led_clr_n_o(led_clr_n)
	);

	tb_shift_monitor u_mon (
		.rst_n_i(rst_n),
		.seg_clk_i(seg_clk),
		.seg_do_i(seg_do),
		.seg_pen_i(seg_pen),
		.led_clk_i(led_clk),
		.led_do_i(led_do),
		.frame_cnt_o(mon_frames),
		.data_o(mon_data),
		.led_o(mon_led),
		.dp_off_o(mon_dp_off),
		.err_cnt_o(mon_errs)
	);

	always @(posedge led_pen) begin
		if (rst_n) begin
			led_pens++;
		end
	end

	task automatic add_step(input switch_t s, input btn_t b, input int hold, input int kind,
		input event_cnt_t cnt);
		tab_sw[n_steps] = s;
		tab_btn[n_steps] = b;
		tab_hold[n_steps] = hold;
		tab_kind[n_steps] = kind;
		tab_cnt[n_steps] = cnt;
		n_steps++;
	endtask

	// hold 0 means a random glitch shorter than the debounce time
	task automatic build_table();
		add_step(16'h0000, 4'h0, 40, K_QUIET, 0);
		add_step(16'h00a5, 4'h0, 0, K_QUIET, 0);
		add_step(16'h0000, 4'h0, FRAME_CYC, K_QUIET, 0);
		// settled values, count starts at zero
		add_step(16'h1234, 4'h0, 20, K_FRAME, 16'd0);
		add_step(16'h5678, 4'h0, 20, K_FRAME, 16'd1);
		add_step(16'h9abc, 4'h0, 20, K_FRAME, 16'd2);
		// each value settles, but much faster than one frame shifts out
		for (int b = 1; b < 9; b++) begin
			add_step(switch_t'(16'h1111 * b), 4'h0, 12, K_BURST, 0);
		end
		add_step(16'hbeef, 4'h0, 12, K_LAST, 0);
		// clear press, then counting restarts at one
		add_step(16'hbeef, 4'h1, 20, K_FRAME, 16'd0);
		add_step(16'hbeef, 4'h0, 20, K_QUIET, 0);
		add_step(16'h0f0f, 4'h0, 20, K_FRAME, 16'd1);
		add_step(16'h0f0f, 4'h0, FRAME_CYC, K_QUIET, 0);
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		assert (act === exp) else begin
			$display("** Error: %s expected %h got %h", name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("** Error: %s expected %h got %h", name, exp, act);
			val_errs++;
		end
	endtask

	// nothing in flight, so the display pins rest
	task automatic check_idle();
		check_bit("seg_pen_o", 1'b0, seg_pen);
		check_bit("led_pen_o", 1'b0, led_pen);
		check_bit("seg_clk_o", 1'b0, seg_clk);
		check_bit("led_clk_o", 1'b0, led_clk);
		check_bit("seg_clr_n_o", 1'b1, seg_clr_n);
		check_bit("led_clr_n_o", 1'b1, led_clr_n);
	endtask

	task automatic check_dp();
		assert (mon_dp_off) else begin
			$display("a decimal point was lit in frame %0d", frames_seen);
			other_errs++;
		end
	endtask

	// back on the drive point after the frame
	task automatic wait_frame();
		wait (mon_frames > frames_seen);
		frames_seen++;
		@(posedge clk_cpu);
		#1;
		// led chain latches once per frame as well
		check_word("led_pen_o pulses", frames_seen, led_pens);
	endtask

	task automatic check_frame(input event_cnt_t cnt, input switch_t exp_sw);
		check_word("seg_do_o digits", {cnt, exp_sw}, mon_data);
		check_word("led_do_o", exp_sw, mon_led);
		check_dp();
		last_cnt = cnt;
	endtask

	// coalesced values may vanish, counts may not
	task automatic drain_burst(input int last_idx);
		int   pos;
		int   k;
		logic done;
		pos = last_idx;
		while (pos > 0 && tab_kind[pos-1] == K_BURST) begin
			pos--;
		end
		done = 1'b0;
		while (!done) begin
			wait_frame();
			last_cnt = last_cnt + 1'b1;
			check_word("seg_do_o count", {16'h0, last_cnt}, {16'h0, mon_data[31:16]});
			// shown value must be a burst entry later than the one before
			k = pos;
			while (k <= last_idx && tab_sw[k] != mon_data[15:0]) begin
				k++;
			end
			assert (k <= last_idx) else begin
				$display("frame %0d shows a switch value outside the burst order",
					frames_seen);
				other_errs++;
			end
			if (k <= last_idx) begin
				check_word("led_do_o", {16'h0, tab_sw[k]}, {16'h0, mon_led});
				pos = k + 1;
			end
			check_dp();
			done = (k == last_idx);
		end
	endtask

	task automatic print_counts();
		$display("value errors: %0d, other errors: %0d, monitor errors: %0d",
			val_errs, other_errs, mon_errs);
	endtask

	initial begin
		int hold;
		int total;
		void'($urandom(22054));
		rst_n = 1'b0;
		sw = '0;
		btn_y = '0;
		n_steps = 0;
		frames_seen = 0;
		led_pens = 0;
		last_cnt = '0;
		val_errs = 0;
		other_errs = 0;
		build_table();
		// watchdog budget from the table
		total = 10;
		for (int i = 0; i < n_steps; i++) begin
			total += (tab_hold[i] == 0) ? JITTER_MAX : tab_hold[i];
			if (tab_kind[i] != K_QUIET) begin
				total += FRAME_CYC;
			end
		end
		limit_cyc = total;
		repeat (8) @(posedge clk_cpu);
		#1;
		rst_n = 1'b1;
		for (int i = 0; i < n_steps; i++) begin
			hold = tab_hold[i];
			if (hold == 0) begin
				hold = 1 + ($urandom % (JITTER_MAX - 1));
			end
			sw = tab_sw[i];
			btn_y = tab_btn[i];
			repeat (hold) begin
				@(posedge clk_cpu);
				#1;
				if (tab_kind[i] == K_QUIET) begin
					check_idle();
				end
			end
			case (tab_kind[i])
				K_QUIET: begin
					assert (mon_frames == frames_seen) else begin
						$display("a frame arrived in step %0d where none was expected", i);
						other_errs++;
					end
				end
				K_FRAME: begin
					wait_frame();
					check_frame(tab_cnt[i], tab_sw[i]);
				end
				K_LAST: begin
					drain_burst(i);
				end
				default: begin
				end
			endcase
		end
		print_counts();
		if (val_errs + other_errs + mon_errs == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// ends a run that waits on a frame forever
	initial begin
		wait (limit_cyc > 0);
		repeat (limit_cyc) @(posedge clk_cpu);
		$display("watchdog expired after %0d cycles, a frame never arrived", limit_cyc);
		print_counts();
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
common/board_pkg.sv
verilog/anti_jitter.sv
switch_probe/switch_probe.sv
verilog/disp_fifo.sv
board_disp/board_disp.sv
verilog/test_frame.sv
testbench/tb_shift_monitor.sv
testbench/tb_test_frame.sv
